//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    // machine word and register index widths.
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // major opcodes handled by the core.
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // alu operations, shared by register and immediate forms.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr,
    dec_exe_if.producer dec
);
    import core_pkg::*;

    logic [xlen-1:0] pc_q;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            funct7_ok;
    alu_op_e         alu_op_d;
    logic [xlen-1:0] imm_d;
    logic            use_imm_d;
    logic            illegal_d;
    logic            accept;

    // funct3 to alu op, alt selects sub or sra.
    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // 0100000 is only defined for add/sub and srl/sra.
    assign funct7_ok = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        alu_op_d  = alu_add;
        imm_d     = '0;
        use_imm_d = 1'b0;
        illegal_d = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op_d  = funct3_op(funct3, funct7[5]);
                illegal_d = !funct7_ok;
            end
            op_imm: begin
                alu_op_d  = funct3_op(funct3, funct3 == 3'b101 && funct7[5]);
                imm_d     = {{(xlen-12){instr[31]}}, instr[31:20]};
                use_imm_d = 1'b1;
                // shift immediates carry funct7 in the upper bits.
                illegal_d = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                            (funct3 == 3'b101 && !funct7_ok);
            end
            op_lui: begin
                alu_op_d  = alu_pass_b;
                imm_d     = {instr[31:12], 12'b0};
                use_imm_d = 1'b1;
            end
            default: begin
                illegal_d = 1'b1;
            end
        endcase
    end

    // register empty or draining this cycle.
    assign instr_ready = !dec.valid || dec.ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q        <= reset_pc;
            dec.valid   <= 1'b0;
            dec.pc      <= '0;
            dec.alu_op  <= alu_add;
            dec.rd      <= '0;
            dec.rs1     <= '0;
            dec.rs2     <= '0;
            dec.imm     <= '0;
            dec.use_imm <= 1'b0;
            dec.illegal <= 1'b0;
        end else if (accept) begin
            pc_q        <= pc_q + xlen'(4);
            dec.valid   <= 1'b1;
            dec.pc      <= pc_q;
            dec.alu_op  <= alu_op_d;
            dec.rd      <= instr[11:7];
            dec.rs1     <= instr[19:15];
            dec.rs2     <= instr[24:20];
            dec.imm     <= imm_d;
            dec.use_imm <= use_imm_d;
            dec.illegal <= illegal_d;
        end else if (dec.ready) begin
            dec.valid   <= 1'b0;
        end
    end

    a_accept_fills: assert property (
        @(posedge clk) disable iff (!rstn) accept |=> dec.valid
    );

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                            clk,
    input  logic                            rstn,
    dec_exe_if.consumer                     dec,
    exe_res_if.producer                     exe,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr_a,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr_b,
    input  logic [core_pkg::xlen-1:0]       rd_data_a,
    input  logic [core_pkg::xlen-1:0]       rd_data_b,
    input  logic                            fwd_valid,
    input  logic [core_pkg::reg_addr_w-1:0] fwd_rd,
    input  logic [core_pkg::xlen-1:0]       fwd_data
);
    import core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;

    // the execute register holds the youngest result and wins over the result register.
    function automatic logic [xlen-1:0] pick_operand(
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       rf_data
    );
        logic exe_hit;
        logic fwd_hit;
        exe_hit = exe.valid && !exe.illegal && exe.rd == src && src != '0;
        fwd_hit = fwd_valid && fwd_rd == src && src != '0;
        if (exe_hit) begin
            return exe.data;
        end else if (fwd_hit) begin
            return fwd_data;
        end
        return rf_data;
    endfunction

    assign rd_addr_a = dec.rs1;
    assign rd_addr_b = dec.rs2;

    assign op_a = pick_operand(dec.rs1, rd_data_a);
    assign op_b = dec.use_imm ? dec.imm : pick_operand(dec.rs2, rd_data_b);

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << op_b[4:0];
            alu_slt:    alu_res = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_res = xlen'(op_a < op_b);
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> op_b[4:0];
            alu_sra:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign dec.ready = !exe.valid || exe.ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exe.valid   <= 1'b0;
            exe.pc      <= '0;
            exe.rd      <= '0;
            exe.data    <= '0;
            exe.illegal <= 1'b0;
        end else if (dec.valid && dec.ready) begin
            exe.valid   <= 1'b1;
            exe.pc      <= dec.pc;
            exe.rd      <= dec.rd;
            // illegal ops carry zero data.
            exe.data    <= dec.illegal ? '0 : alu_res;
            exe.illegal <= dec.illegal;
        end else if (exe.ready) begin
            exe.valid   <= 1'b0;
        end
    end

    a_dec_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (dec.valid && !dec.ready) |=> dec.valid &&
            $stable({dec.pc, dec.alu_op, dec.rd, dec.rs1, dec.rs2,
                     dec.imm, dec.use_imm, dec.illegal})
    );

endmodule

`default_nettype wire

//--- design/int_core.sv
`default_nettype none

module int_core #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            instr_valid,
    output logic                            instr_ready,
    input  logic [31:0]                     instr,
    output logic                            commit_valid,
    input  logic                            commit_ready,
    output logic [core_pkg::xlen-1:0]       commit_pc,
    output logic [core_pkg::reg_addr_w-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]       commit_data,
    output logic                            commit_illegal
);
    import core_pkg::*;

    logic [reg_addr_w-1:0] rd_addr_a;
    logic [reg_addr_w-1:0] rd_addr_b;
    logic [xlen-1:0]       rd_data_a;
    logic [xlen-1:0]       rd_data_b;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;
    logic                  fwd_valid;
    logic [reg_addr_w-1:0] fwd_rd;
    logic [xlen-1:0]       fwd_data;

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    decode_stage #(.reset_pc(reset_pc)) decode_i (
        .clk, .rstn, .instr_valid, .instr_ready, .instr,
        .dec (dec_exe.producer)
    );

    execute_stage execute_i (
        .clk, .rstn,
        .dec (dec_exe.consumer),
        .exe (exe_res.producer),
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .fwd_valid, .fwd_rd, .fwd_data
    );

    register_file regfile_i (
        .clk, .rstn, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_en, .wr_addr, .wr_data
    );

    result_stage result_i (
        .clk, .rstn,
        .exe (exe_res.consumer),
        .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_data, .commit_illegal,
        .wr_en, .wr_addr, .wr_data,
        .fwd_valid, .fwd_rd, .fwd_data
    );

endmodule

`default_nettype wire

//--- design/pipe_if.sv
`default_nettype none

// decode register to execute.
interface dec_exe_if;
    import core_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [xlen-1:0]       pc;
    alu_op_e               alu_op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    logic                  use_imm;
    logic                  illegal;

    modport producer (
        output valid, pc, alu_op, rd, rs1, rs2, imm, use_imm, illegal,
        input  ready
    );
    modport consumer (
        input  valid, pc, alu_op, rd, rs1, rs2, imm, use_imm, illegal,
        output ready
    );
endinterface

// execute register to result.
interface exe_res_if;
    import core_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  illegal;

    modport producer (output valid, pc, rd, data, illegal, input ready);
    modport consumer (input valid, pc, rd, data, illegal, output ready);
endinterface

`default_nettype wire

//--- design/register_file.sv
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [core_pkg::reg_addr_w-1:0] rd_addr_a,
    input  logic [core_pkg::reg_addr_w-1:0] rd_addr_b,
    output logic [core_pkg::xlen-1:0]       rd_data_a,
    output logic [core_pkg::xlen-1:0]       rd_data_b,
    input  logic                            wr_en,
    input  logic [core_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [core_pkg::xlen-1:0]       wr_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 is hardwired.
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

    // result stage filters x0 before it gets here.
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rstn) !(wr_en && wr_addr == '0)
    );

endmodule

`default_nettype wire

//--- design/result_stage.sv
`default_nettype none

module result_stage (
    input  logic                            clk,
    input  logic                            rstn,
    exe_res_if.consumer                     exe,
    output logic                            commit_valid,
    input  logic                            commit_ready,
    output logic [core_pkg::xlen-1:0]       commit_pc,
    output logic [core_pkg::reg_addr_w-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]       commit_data,
    output logic                            commit_illegal,
    output logic                            wr_en,
    output logic [core_pkg::reg_addr_w-1:0] wr_addr,
    output logic [core_pkg::xlen-1:0]       wr_data,
    output logic                            fwd_valid,
    output logic [core_pkg::reg_addr_w-1:0] fwd_rd,
    output logic [core_pkg::xlen-1:0]       fwd_data
);

    assign exe.ready = !commit_valid || commit_ready;

    // result register drives the commit port directly.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            commit_valid   <= 1'b0;
            commit_pc      <= '0;
            commit_rd      <= '0;
            commit_data    <= '0;
            commit_illegal <= 1'b0;
        end else if (exe.valid && exe.ready) begin
            commit_valid   <= 1'b1;
            commit_pc      <= exe.pc;
            commit_rd      <= exe.rd;
            commit_data    <= exe.data;
            commit_illegal <= exe.illegal;
        end else if (commit_ready) begin
            commit_valid   <= 1'b0;
        end
    end

    // architectural write at the commit handshake.
    assign wr_en   = commit_valid && commit_ready && !commit_illegal && commit_rd != '0;
    assign wr_addr = commit_rd;
    assign wr_data = commit_data;

    assign fwd_valid = commit_valid && !commit_illegal;
    assign fwd_rd    = commit_rd;
    assign fwd_data  = commit_data;

    a_commit_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (commit_valid && !commit_ready) |=> commit_valid && $stable(commit_data)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module core_tb \
    -f src.f > sim.log 2>&1 &&
./obj_dir/Vcore_tb >> sim.log 2>&1 ||
echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

//--- sim/core_model.svh
`ifndef core_model_svh
`define core_model_svh

// random source state and the architectural registers of the model.
logic [31:0] lfsr_state;
logic [31:0] model_regs [32];

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// low register indices only, so results get reused soon.
function automatic logic [31:0] make_instr();
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] word;
    kind = 4'(take_bits(4));
    f3   = 3'(take_bits(3));
    rd   = 5'(take_bits(3));
    rs1  = 5'(take_bits(3));
    rs2  = 5'(take_bits(3));
    imm  = 12'(take_bits(12));
    f7   = (take_bits(1) == 1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    if (kind == 4'd0) begin
        // bad opcode with bit 6 set, or a reserved funct7.
        word = take_bits(32);
        if (imm[0]) begin
            return {word[31:7], word[6:0] | 7'h40};
        end else if (imm[1]) begin
            return {f7 | 7'h01, rs2, rs1, f3, rd, 7'h33};
        end
        return {f7 | 7'h01, imm[4:0], rs1, imm[2] ? 3'd1 : 3'd5, rd, 7'h13};
    end else if (kind < 4'd7) begin
        return {f7, rs2, rs1, f3, rd, 7'h33};
    end else if (kind < 4'd13) begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
            return {f7, imm[4:0], rs1, f3, rd, 7'h13};
        end
        return {imm, rs1, f3, rd, 7'h13};
    end
    word = take_bits(20);
    return {word[19:0], rd, 7'h37};
endfunction

// executes one instruction on the model in program order.
function automatic void predict_commit(input logic [31:0] ins, output logic [31:0] data,
                                       output logic illegal);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic        alt;
    f3  = ins[14:12];
    f7  = ins[31:25];
    a   = model_regs[ins[19:15]];
    b   = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
    // sub and sra use funct7 0100000, op-imm only on shifts.
    alt = f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && ins[6:0] == 7'h33));
    illegal = (ins[6:0] == 7'h33 && f7 != 7'h00 && !alt) ||
              (ins[6:0] == 7'h13 && (f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00 && !alt) ||
              (ins[6:0] != 7'h33 && ins[6:0] != 7'h13 && ins[6:0] != 7'h37);
    case (f3)
        3'd0:    data = alt ? a - b : a + b;
        3'd1:    data = a << b[4:0];
        3'd2:    data = {31'b0, $signed(a) < $signed(b)};
        3'd3:    data = {31'b0, a < b};
        3'd4:    data = a ^ b;
        3'd5:    data = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    data = a | b;
        default: data = a & b;
    endcase
    if (ins[6:0] == 7'h37) begin
        data = {ins[31:12], 12'b0};
    end
    if (illegal) begin
        data = '0;
    end else if (ins[11:7] != 5'd0) begin
        model_regs[ins[11:7]] = data;
    end
endfunction

`endif

//--- sim/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          num_instr = 2000;
    localparam logic [31:0] start_pc  = 32'h0000_1000;

    logic        clk;
    logic        rstn;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        commit_valid;
    logic        commit_ready;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_illegal;

    // expected commits {pc, rd, data, illegal} in program order.
    logic [69:0] expected [$];
    logic [69:0] held_payload;
    logic        held;
    logic [31:0] model_pc;
    int          accepted;
    int          issued;
    int          stall_left;

    `include "core_model.svh"

    int_core #(.reset_pc(start_pc)) dut_i (
        .clk, .rstn, .instr_valid, .instr_ready, .instr,
        .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_data, .commit_illegal
    );

    always #5 clk = ~clk;

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error: at %0t %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_commit();
        logic [69:0] e;
        assert (expected.size() > 0) else begin
            $display("Error: a commit arrived at %0t with nothing outstanding", $time);
            stop_on_error();
        end
        e = expected.pop_front();
        check_field("commit_pc", commit_pc, e[69:38]);
        check_field("commit_rd", 32'(commit_rd), 32'(e[37:33]));
        check_field("commit_data", commit_data, e[32:1]);
        check_field("commit_illegal", 32'(commit_illegal), 32'(e[0]));
    endtask

    // a stalled commit must keep its whole payload.
    task automatic check_hold();
        if (held) begin
            assert (commit_valid) else begin
                $display("Error: commit_valid dropped at %0t while stalled", $time);
                stop_on_error();
            end
            assert ({commit_pc, commit_rd, commit_data, commit_illegal} == held_payload) else begin
                $display("Error: at %0t commit payload is %h, expected %h", $time,
                         {commit_pc, commit_rd, commit_data, commit_illegal}, held_payload);
                stop_on_error();
            end
        end
        held         = commit_valid && !commit_ready;
        held_payload = {commit_pc, commit_rd, commit_data, commit_illegal};
    endtask

    task automatic accept_instr();
        logic [31:0] data;
        logic        illegal;
        predict_commit(instr, data, illegal);
        expected.push_back({model_pc, instr[11:7], data, illegal});
        model_pc = model_pc + 32'd4;
        accepted++;
    endtask

    task automatic drive_inputs(input logic accepted_now);
        if (accepted_now || !instr_valid) begin
            // about a quarter of the slots stay empty.
            if (issued < num_instr && take_bits(2) != 0) begin
                instr       = make_instr();
                instr_valid = 1'b1;
                issued++;
            end else begin
                instr       = take_bits(32);
                instr_valid = 1'b0;
            end
        end
        if (stall_left > 0) begin
            stall_left--;
            commit_ready = 1'b0;
        end else if (take_bits(6) == 0) begin
            // a long stall fills the pipeline.
            stall_left   = 6;
            commit_ready = 1'b0;
        end else begin
            commit_ready = take_bits(2) != 0;
        end
    endtask

    initial begin
        logic acc;
        clk          = 1'b0;
        rstn         = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_ready = 1'b0;
        lfsr_state   = 32'h0e5060a3;
        model_pc     = start_pc;
        accepted     = 0;
        issued       = 0;
        stall_left   = 0;
        held         = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        while (accepted < num_instr) begin
            @(posedge clk);
            check_hold();
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            acc = instr_valid && instr_ready;
            if (acc) begin
                accept_instr();
            end
            @(negedge clk);
            drive_inputs(acc);
        end
        // with commit_ready high the three stage registers empty in three cycles.
        instr_valid  = 1'b0;
        commit_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_hold();
            if (commit_valid) begin
                check_commit();
            end
        end
        // the drained pipeline must stay quiet.
        repeat (4) begin
            @(posedge clk);
            assert (!commit_valid) else begin
                $display("Error: an extra commit appeared at %0t", $time);
                stop_on_error();
            end
        end
        if (expected.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Error: %0d expected commits never arrived", expected.size());
            stop_on_error();
        end
    end

    initial begin
        repeat (10 * num_instr + 100) @(posedge clk);
        $display("Error: the run timed out after %0d cycles", 10 * num_instr + 100);
        stop_on_error();
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+sim
design/core_pkg.sv
design/pipe_if.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/int_core.sv
sim/core_tb.sv
